/* bus_ctl.sv */
`timescale 1ns/1ps

module bus_ctl (
	input logic clk,
	input logic reset,
	input mera400_pkg::panel_op_t panel_op,
	input logic [mera400_pkg::data_w-1:0] kl,
	input logic clm_,
	input logic ok_,
	input logic [mera400_pkg::data_w-1:0] rdt,
	output logic r_,
	output logic w_,
	output logic [mera400_pkg::data_w-1:0] ddt,
	output logic ar_load,
	output logic ar_inc,
	output logic [mera400_pkg::data_w-1:0] w,
	output logic busy,
	output logic awaria
);

	import mera400_pkg::*;

	bus_state_t state;
	// current cycle is a write
	logic wr_cycle;
	logic [bus_timeout_w-1:0] wd_cnt;
	logic accept;
	logic mem_op;

	// panel operations only taken when idle and not clearing
	assign accept = (state == st_idle) && clm_;
	assign mem_op = (panel_op == op_fetch) || (panel_op == op_store);

	// load finishes right away, no bus cycle
	assign ar_load = accept && (panel_op == op_load);
	// release state is only reached after ok
	assign ar_inc = (state == st_release);
	assign busy = (state != st_idle);
	assign awaria = (state == st_alarm);

	// ----------------------------------------
	// bus cycle FSM
	// ----------------------------------------

	always_ff @(posedge clk) begin
		if (reset || !clm_) begin
			state <= st_idle;
			r_ <= 1'b1;
			w_ <= 1'b1;
			wr_cycle <= 1'b0;
			wd_cnt <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (accept && mem_op) begin
						wr_cycle <= (panel_op == op_store);
						r_ <= (panel_op != op_fetch);
						w_ <= (panel_op != op_store);
						wd_cnt <= '0;
						state <= st_req;
					end
				end
				st_req: begin
					if (!ok_) begin
						// memory answered, drop the request
						r_ <= 1'b1;
						w_ <= 1'b1;
						state <= st_release;
					end else if (wd_cnt == bus_timeout_w'(bus_timeout_ticks - 1)) begin
						// nobody home at this address
						r_ <= 1'b1;
						w_ <= 1'b1;
						state <= st_alarm;
					end else begin
						wd_cnt <= wd_cnt + 1'b1;
					end
				end
				st_release: begin
					state <= st_idle;
				end
				// alarm sticks until general clear
				st_alarm: begin
					state <= st_alarm;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

	// w display, read data shows as busy drops
	always_ff @(posedge clk) begin
		if (reset) begin
			w <= '0;
		end else if (clm_ && (state == st_release) && !wr_cycle) begin
			w <= rdt;
		end
	end

	// store data taken from the keys
	always_ff @(posedge clk) begin
		if (accept && (panel_op == op_store)) begin
			ddt <= kl;
		end
	end

	// one request direction at a time
	a_rw_excl: assert property (@(posedge clk) disable iff (reset) (r_ || w_));

	// alarm never advances the address register
	a_alarm_no_inc: assert property (@(posedge clk) disable iff (reset)
		(state == st_alarm) && clm_ |=> !ar_inc);

endmodule

/* mem_elwro.sv */
`timescale 1ns/1ps

module mem_elwro (
	input logic clk,
	input logic reset,
	input logic [mera400_pkg::nb_w-1:0] nb,
	input logic [mera400_pkg::addr_w-1:0] ad,
	input logic [mera400_pkg::data_w-1:0] ddt,
	input logic r_,
	input logic w_,
	output logic [mera400_pkg::data_w-1:0] rdt,
	output logic ok_
);

	import mera400_pkg::*;

	// ----------------------------------------
	// address decode
	// ----------------------------------------

	logic [data_w-1:0] mem [mem_words];
	logic [mem_index_w-1:0] idx;
	logic present;
	logic req;
	logic access;
	logic [mem_access_w-1:0] acc_cnt;

	// only low segments are fitted
	assign present = (nb < nb_w'(mem_segments));
	assign req = !r_ || !w_;
	// upper address bits not decoded so addresses alias
	assign idx = {nb[seg_w-1:0], ad[mem_addr_w-1:0]};

	// last tick of the access delay
	assign access = req && present && ok_
		&& (acc_cnt == mem_access_w'(mem_access_ticks - 1));

	// ----------------------------------------
	// request / ok handshake
	// ----------------------------------------

	// ok held low while the request stays low
	// released one cycle after the request goes away
	always_ff @(posedge clk) begin
		if (reset) begin
			ok_ <= 1'b1;
			acc_cnt <= '0;
		end else if (!req) begin
			ok_ <= 1'b1;
			acc_cnt <= '0;
		end else if (access) begin
			ok_ <= 1'b0;
		end else if (present && ok_) begin
			acc_cnt <= acc_cnt + 1'b1;
		end
	end

	// ----------------------------------------
	// storage
	// ----------------------------------------

	// write from ddt, read into rdt, once per cycle
	always_ff @(posedge clk) begin
		if (access) begin
			if (!w_) begin
				mem[idx] <= ddt;
			end else begin
				rdt <= mem[idx];
			end
		end
	end

	// no stray ok on an idle bus
	a_ok_window: assert property (@(posedge clk) disable iff (reset)
		!ok_ |-> (req || $past(req)));

endmodule

/* mera400_bus_top.sv */
`timescale 1ns/1ps

module mera400_bus_top (
	input logic clk_ext,
	input logic reset,
	input logic [mera400_pkg::data_w-1:0] kl,
	input logic [mera400_pkg::nb_w-1:0] nb_sel,
	input logic panel_load,
	input logic panel_fetch,
	input logic panel_store,
	input logic panel_clear,
	output logic [mera400_pkg::data_w-1:0] w,
	output logic [mera400_pkg::addr_w-1:0] ar,
	output logic busy,
	output logic awaria
);

	import mera400_pkg::*;

	// ----------------------------------------
	// panel and bus wiring
	// ----------------------------------------

	panel_op_t panel_op;
	logic ar_load;
	logic ar_inc;
	logic clm_;
	// system bus
	logic r_;
	logic w_;
	logic ok_;
	logic [nb_w-1:0] nb;
	logic [data_w-1:0] ddt;
	logic [data_w-1:0] rdt;

	// ar register drives the bus address lines directly
	panel_ar panel_ar_inst (
		.clk(clk_ext),
		.reset(reset),
		.kl(kl),
		.nb_sel(nb_sel),
		.panel_load(panel_load),
		.panel_fetch(panel_fetch),
		.panel_store(panel_store),
		.clm_(clm_),
		.ar_load(ar_load),
		.ar_inc(ar_inc),
		.panel_op(panel_op),
		.ad(ar),
		.nb(nb)
	);

	bus_ctl bus_ctl_inst (
		.clk(clk_ext),
		.reset(reset),
		.panel_op(panel_op),
		.kl(kl),
		.clm_(clm_),
		.ok_(ok_),
		.rdt(rdt),
		.r_(r_),
		.w_(w_),
		.ddt(ddt),
		.ar_load(ar_load),
		.ar_inc(ar_inc),
		.w(w),
		.busy(busy),
		.awaria(awaria)
	);

	// power supply clear
	puks puks_inst (
		.clk(clk_ext),
		.reset(reset),
		.panel_clear(panel_clear),
		.clm_(clm_)
	);

	mem_elwro mem_elwro_inst (
		.clk(clk_ext),
		.reset(reset),
		.nb(nb),
		.ad(ar),
		.ddt(ddt),
		.r_(r_),
		.w_(w_),
		.rdt(rdt),
		.ok_(ok_)
	);

endmodule

/* mera400_pkg.sv */
package mera400_pkg;

	// ----------------------------------------
	// system bus widths
	// ----------------------------------------

	localparam int data_w = 16;
	localparam int addr_w = 16;
	localparam int nb_w = 4;

	// ----------------------------------------
	// memory module geometry
	// ----------------------------------------

	// word address bits decoded within one segment
	localparam int mem_addr_w = 10;
	// segments 0 .. mem_segments-1 are present
	localparam int mem_segments = 2;
	localparam int seg_w = $clog2(mem_segments);
	localparam int mem_index_w = seg_w + mem_addr_w;
	localparam int mem_words = mem_segments << mem_addr_w;

	// ----------------------------------------
	// timing, in clk cycles
	// ----------------------------------------

	// request seen -> ok
	localparam int mem_access_ticks = 3;
	localparam int mem_access_w = $clog2(mem_access_ticks + 1);
	// no ok within this many cycles means alarm
	localparam int bus_timeout_ticks = 15;
	localparam int bus_timeout_w = $clog2(bus_timeout_ticks + 1);
	// general clear length
	localparam int clear_ticks = 8;
	localparam int clear_w = $clog2(clear_ticks + 1);

	// panel key operations
	typedef enum logic [1:0] {op_none, op_load, op_fetch, op_store} panel_op_t;

	// bus sequencer states
	typedef enum logic [1:0] {st_idle, st_req, st_release, st_alarm} bus_state_t;

endpackage

/* panel_ar.sv */
`timescale 1ns/1ps

module panel_ar (
	input logic clk,
	input logic reset,
	input logic [mera400_pkg::data_w-1:0] kl,
	input logic [mera400_pkg::nb_w-1:0] nb_sel,
	input logic panel_load,
	input logic panel_fetch,
	input logic panel_store,
	input logic clm_,
	input logic ar_load,
	input logic ar_inc,
	output mera400_pkg::panel_op_t panel_op,
	output logic [mera400_pkg::addr_w-1:0] ad,
	output logic [mera400_pkg::nb_w-1:0] nb
);

	import mera400_pkg::*;

	// ----------------------------------------
	// key encoder
	// ----------------------------------------

	// load wins over store, store over fetch
	always_comb begin
		if (panel_load) begin
			panel_op = op_load;
		end else if (panel_store) begin
			panel_op = op_store;
		end else if (panel_fetch) begin
			panel_op = op_fetch;
		end else begin
			panel_op = op_none;
		end
	end

	// ----------------------------------------
	// address and segment registers
	// ----------------------------------------

	// general clear zeroes both registers
	// load takes keys and segment switches
	// increment wraps at the top of the address space
	always_ff @(posedge clk) begin
		if (reset || !clm_) begin
			ad <= '0;
			nb <= '0;
		end else if (ar_load) begin
			ad <= kl;
			nb <= nb_sel;
		end else if (ar_inc) begin
			ad <= ad + 1'b1;
		end
	end

endmodule

/* puks.sv */
`timescale 1ns/1ps

module puks (
	input logic clk,
	input logic reset,
	input logic panel_clear,
	output logic clm_
);

	import mera400_pkg::*;

	// ----------------------------------------
	// general clear timer
	// ----------------------------------------

	// cycles of clear still to go
	logic [clear_w-1:0] clr_cnt;

	// reset and panel clear both restart the full clear
	always_ff @(posedge clk) begin
		if (reset || panel_clear) begin
			clr_cnt <= clear_w'(clear_ticks);
		end else if (clr_cnt != '0) begin
			clr_cnt <= clr_cnt - 1'b1;
		end
	end

	// clear active (low) until counter runs out
	assign clm_ = (clr_cnt == '0);

	// full clear length after every reset
	a_clear_len: assert property (@(posedge clk)
		$fell(reset) |-> !clm_ [*clear_ticks]);

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass decided from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f verilog.f \
	--top-module tb_mera400_bus -o tb_mera400_bus_sim > build.log 2>&1 \
	&& ./obj_dir/tb_mera400_bus_sim > sim.log 2>&1 \
	|| echo "build or simulation returned an error, see build.log and sim.log"
grep -qx "TEST PASS" sim.log \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }

/* tb_mera400_bus.sv */
`timescale 1ns/1ps

module tb_mera400_bus;

	import mera400_pkg::*;

	localparam time clk_period = 100ns;
	// upper bound on panel operations in the whole run
	localparam int max_ops = 150;

	logic clk_ext;
	logic reset;
	logic [data_w-1:0] kl;
	logic [nb_w-1:0] nb_sel;
	logic panel_load;
	logic panel_fetch;
	logic panel_store;
	logic panel_clear;
	logic [data_w-1:0] w;
	logic [addr_w-1:0] ar;
	logic busy;
	logic awaria;

	// reference memory indexed by segment and word
	logic [data_w-1:0] ref_mem [mem_segments][1 << mem_addr_w];
	// expected panel registers
	logic [nb_w-1:0] exp_nb;
	logic [addr_w-1:0] exp_ar;
	logic [data_w-1:0] w_hold;
	integer seed;
	integer rnd;

	mera400_bus_top mera400_bus_top_inst (.*);

	initial begin
		clk_ext = 1'b0;
		forever #(clk_period / 2) clk_ext = ~clk_ext;
	end

	task automatic check_value(input string name, input logic [15:0] actual,
		input logic [15:0] expected);
		if (actual !== expected) begin
			$display("[ERROR] %0t: %s = %h, expected %h", $time, name, actual, expected);
			$display("TEST FAIL");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// ----------------------------------------
	// panel key helpers
	// ----------------------------------------

	// one-cycle strobe, then wait for the sequencer
	task automatic press(input panel_op_t op);
		@(negedge clk_ext);
		panel_load = (op == op_load);
		panel_fetch = (op == op_fetch);
		panel_store = (op == op_store);
		@(negedge clk_ext);
		panel_load = 1'b0;
		panel_fetch = 1'b0;
		panel_store = 1'b0;
		// alarm holds busy high for good
		while (busy && !awaria) begin
			@(negedge clk_ext);
		end
	endtask

	task automatic load_ar(input logic [nb_w-1:0] seg, input logic [addr_w-1:0] addr);
		kl = addr;
		nb_sel = seg;
		press(op_load);
		exp_nb = seg;
		exp_ar = addr;
		check_value("ar", ar, exp_ar);
	endtask

	task automatic store_words(input int n);
		repeat (n) begin
			rnd = $random(seed);
			kl = rnd[15:0];
			press(op_store);
			ref_mem[exp_nb[seg_w-1:0]][exp_ar[mem_addr_w-1:0]] = kl;
			exp_ar = exp_ar + 16'd1;
			check_value("ar", ar, exp_ar);
			check_value("busy", 16'(busy), 16'h0);
		end
	endtask

	task automatic fetch_words(input int n);
		repeat (n) begin
			press(op_fetch);
			check_value("w", w, ref_mem[exp_nb[seg_w-1:0]][exp_ar[mem_addr_w-1:0]]);
			exp_ar = exp_ar + 16'd1;
			check_value("ar", ar, exp_ar);
			check_value("awaria", 16'(awaria), 16'h0);
		end
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------

	task automatic test_reset_state();
		check_value("busy", 16'(busy), 16'h0);
		check_value("awaria", 16'(awaria), 16'h0);
		check_value("w", w, 16'h0);
		check_value("ar", ar, 16'h0);
	endtask

	task automatic test_store_fetch();
		load_ar(4'd0, 16'h0120);
		store_words(16);
		load_ar(4'd0, 16'h0120);
		fetch_words(16);
	endtask

	// same low addresses in segment 1, then aliased reads
	task automatic test_segments();
		load_ar(4'd1, 16'h0120);
		store_words(8);
		load_ar(4'd0, 16'h0120);
		fetch_words(16);
		load_ar(4'd1, 16'h0120);
		fetch_words(8);
		load_ar(4'd0, 16'h0520);
		fetch_words(4);
		load_ar(4'd1, 16'hfd20);
		fetch_words(2);
		// ar wraps to zero after the top address
		load_ar(4'd0, 16'hffff);
		store_words(1);
		load_ar(4'd0, 16'h03ff);
		fetch_words(1);
	endtask

	task automatic test_absent_segment();
		load_ar(4'd2, 16'h0200);
		w_hold = w;
		press(op_fetch);
		check_value("awaria", 16'(awaria), 16'h1);
		check_value("busy", 16'(busy), 16'h1);
		check_value("w", w, w_hold);
		check_value("ar", ar, exp_ar);
		// store while in alarm is dropped
		rnd = $random(seed);
		kl = rnd[15:0];
		@(negedge clk_ext);
		panel_store = 1'b1;
		@(negedge clk_ext);
		panel_store = 1'b0;
		// an accepted store would leave alarm for a new request
		check_value("awaria", 16'(awaria), 16'h1);
		check_value("ar", ar, exp_ar);
	endtask

	task automatic test_panel_clear();
		@(negedge clk_ext);
		panel_clear = 1'b1;
		@(negedge clk_ext);
		panel_clear = 1'b0;
		repeat (clear_ticks + 2) @(negedge clk_ext);
		check_value("awaria", 16'(awaria), 16'h0);
		check_value("busy", 16'(busy), 16'h0);
		check_value("ar", ar, 16'h0);
		// memory keeps its contents through clear
		load_ar(4'd0, 16'h0120);
		fetch_words(16);
		load_ar(4'd1, 16'h0120);
		fetch_words(8);
		load_ar(4'd0, 16'h03ff);
		fetch_words(1);
	endtask

	// watchdog sized from the longest bus cycle per operation
	initial begin
		repeat (max_ops * (bus_timeout_ticks + 10) + 100) @(posedge clk_ext);
		$display("watchdog expired before the tests finished");
		$display("TEST FAIL");
		$fatal(1, "timeout");
	end

	initial begin
		seed = 32'hd186_48ea;
		reset = 1'b1;
		kl = '0;
		nb_sel = '0;
		panel_load = 1'b0;
		panel_fetch = 1'b0;
		panel_store = 1'b0;
		panel_clear = 1'b0;
		exp_nb = '0;
		exp_ar = '0;
		repeat (4) @(posedge clk_ext);
		@(negedge clk_ext);
		reset = 1'b0;
		// general clear runs out after reset
		repeat (clear_ticks + 2) @(negedge clk_ext);
		test_reset_state();
		test_store_fetch();
		test_segments();
		test_absent_segment();
		test_panel_clear();
		$display("TEST PASS");
		$finish;
	end

endmodule

/* verilog.f */
mera400_pkg.sv
panel_ar.sv
bus_ctl.sv
puks.sv
mem_elwro.sv
mera400_bus_top.sv
tb_mera400_bus.sv
